/* logic/sigmul_pkg.sv */
package sigmul_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int NSIG_DEFAULT = 10;

  // Tree level whose result is registered
  localparam int REG_LEVEL = 2;

  // Fraction plus hidden bit
  function automatic int sig_width(int nsig);
    return nsig + 1;
  endfunction

  function automatic int prod_width(int nsig);
    return 2 * sig_width(nsig);
  endfunction

  //////////////////////////////
  // Reduction tree shape
  //////////////////////////////

  // Each level maps every group of three rows to two, leftovers pass
  function automatic int rows_after(int rows, int levels);
    int n;
    n = rows;
    for (int l = 0; l < levels; l++)
    begin
      n = (n / 3) * 2 + n % 3;
    end
    return n;
  endfunction

  function automatic int csa_levels(int nsig);
    int lv;
    lv = 0;
    while (rows_after(sig_width(nsig), lv) > 2)
    begin
      lv++;
    end
    return lv;
  endfunction

endpackage

/* logic/sigmul_pp_decode.sv */
module sigmul_pp_decode #(
  parameter int NSIG = sigmul_pkg::NSIG_DEFAULT
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic [NSIG-1:0] a_frac,
  input  logic [NSIG-1:0] b_frac,
  input  logic            a_zero_exp,
  input  logic            b_zero_exp,
  output logic            pp_valid,
  output logic [sigmul_pkg::sig_width(NSIG)-1:0]
               [sigmul_pkg::prod_width(NSIG)-1:0] pp_rows
);

  import sigmul_pkg::*;

  localparam int SW = sig_width(NSIG);
  localparam int PW = prod_width(NSIG);

  logic [SW-1:0]          a_sig;
  logic [SW-1:0]          b_sig;
  logic [SW-1:0][PW-1:0]  pp_next;

  // Hidden bit is clear for a subnormal operand
  assign a_sig = {~a_zero_exp, a_frac};
  assign b_sig = {~b_zero_exp, b_frac};

  //////////////////////////////
  // Partial products
  //////////////////////////////

  // One row per multiplier bit, already at its weight
  for (genvar i = 0; i < SW; i++)
  begin : g_row
    assign pp_next[i] = PW'(a_sig & {SW{b_sig[i]}}) << i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      pp_valid <= 1'b0;
    else
      pp_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
      pp_rows <= pp_next;
  end

  // Nothing leaves decode right after a reset edge
  a_no_valid_after_rst : assert property (
    @(posedge clk) rst |=> !pp_valid
  );

endmodule

/* logic/sigmul_csa_tree.sv */
module sigmul_csa_tree #(
  parameter int NSIG = sigmul_pkg::NSIG_DEFAULT
) (
  input  logic clk,
  input  logic rst,
  input  logic pp_valid,
  input  logic [sigmul_pkg::sig_width(NSIG)-1:0]
               [sigmul_pkg::prod_width(NSIG)-1:0] pp_rows,
  output logic red_valid,
  output logic [sigmul_pkg::prod_width(NSIG)-1:0] red_sum,
  output logic [sigmul_pkg::prod_width(NSIG)-1:0] red_carry
);

  import sigmul_pkg::*;

  localparam int SW       = sig_width(NSIG);
  localparam int PW       = prod_width(NSIG);
  localparam int NLEV     = csa_levels(NSIG);
  localparam int MID_ROWS = rows_after(SW, REG_LEVEL);

  // Rows held between the two halves of the tree
  logic [PW-1:0] mid_q [MID_ROWS];

  //////////////////////////////
  // 3:2 levels
  //////////////////////////////

  for (genvar lv = 0; lv < NLEV; lv++)
  begin : g_lvl
    localparam int NIN  = rows_after(SW, lv);
    localparam int NOUT = rows_after(SW, lv + 1);
    localparam int NGRP = NIN / 3;

    logic [PW-1:0] rin  [NIN];
    logic [PW-1:0] rout [NOUT];

    // Level input: decode rows, the register, or the level before
    if (lv == 0)
    begin : g_src_pp
      for (genvar r = 0; r < NIN; r++)
      begin : g_unpack
        assign rin[r] = pp_rows[r];
      end
    end
    else if (lv == REG_LEVEL)
    begin : g_src_reg
      assign rin = mid_q;
    end
    else
    begin : g_src_prev
      assign rin = g_lvl[lv-1].rout;
    end

    // Full adders across the whole row width
    for (genvar k = 0; k < NGRP; k++)
    begin : g_grp
      logic [PW-1:0] x;
      logic [PW-1:0] y;
      logic [PW-1:0] z;

      assign x = rin[3*k];
      assign y = rin[3*k+1];
      assign z = rin[3*k+2];

      assign rout[2*k]   = x ^ y ^ z;
      // Top majority bit is always zero, the product fits PW bits
      assign rout[2*k+1] = ((x & y) | (x & z) | (y & z)) << 1;
    end

    // One or two rows left over go straight through
    for (genvar j = 0; j < NIN - 3 * NGRP; j++)
    begin : g_pass
      assign rout[2*NGRP+j] = rin[3*NGRP+j];
    end
  end

  //////////////////////////////
  // Pipeline register
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      red_valid <= 1'b0;
    else
      red_valid <= pp_valid;
  end

  always_ff @(posedge clk)
  begin
    if (pp_valid)
      mid_q <= g_lvl[REG_LEVEL-1].rout;
  end

  // Later levels are combinational after the register
  assign red_sum   = g_lvl[NLEV-1].rout[0];
  assign red_carry = g_lvl[NLEV-1].rout[1];

  a_valid_follows : assert property (
    @(posedge clk) disable iff (rst) pp_valid |=> red_valid
  );

endmodule

/* logic/sigmul_result.sv */
module sigmul_result #(
  parameter int NSIG = sigmul_pkg::NSIG_DEFAULT
) (
  input  logic clk,
  input  logic rst,
  input  logic red_valid,
  input  logic [sigmul_pkg::prod_width(NSIG)-1:0] red_sum,
  input  logic [sigmul_pkg::prod_width(NSIG)-1:0] red_carry,
  output logic out_valid,
  output logic [sigmul_pkg::sig_width(NSIG)-1:0] sig,
  output logic exp_inc,
  output logic guard,
  output logic sticky
);

  import sigmul_pkg::*;

  localparam int SW = sig_width(NSIG);
  localparam int PW = prod_width(NSIG);

  logic          p_cout;
  logic [PW-1:0] p;
  logic [PW-1:0] norm;

  //////////////////////////////
  // Final add
  //////////////////////////////

  assign {p_cout, p} = {1'b0, red_sum} + {1'b0, red_carry};

  // Product lies in [1,4) when both hidden bits are set
  // Shift left once unless the top bit is already set
  assign norm = p[PW-1] ? p : {p[PW-2:0], 1'b0};

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= red_valid;
  end

  always_ff @(posedge clk)
  begin
    if (red_valid)
    begin
      sig     <= norm[PW-1 -: SW];
      exp_inc <= p[PW-1];
      guard   <= norm[PW-1-SW];
      // Zero shifted in at the bottom does not disturb sticky
      sticky  <= |norm[PW-2-SW:0];
    end
  end

  // Sum and carry from the tree never overflow the product width
  a_no_carry_out : assert property (
    @(posedge clk) disable iff (rst) red_valid |-> !p_cout
  );

endmodule

/* logic/sigmul_top.sv */
module sigmul_top #(
  parameter int NSIG = sigmul_pkg::NSIG_DEFAULT
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic [NSIG-1:0] a_frac,
  input  logic [NSIG-1:0] b_frac,
  input  logic            a_zero_exp,
  input  logic            b_zero_exp,
  output logic            out_valid,
  output logic [sigmul_pkg::sig_width(NSIG)-1:0] sig,
  output logic            exp_inc,
  output logic            guard,
  output logic            sticky
);

  import sigmul_pkg::*;

  localparam int SW = sig_width(NSIG);
  localparam int PW = prod_width(NSIG);

  logic                  pp_valid;
  logic [SW-1:0][PW-1:0] pp_rows;
  logic                  red_valid;
  logic [PW-1:0]         red_sum;
  logic [PW-1:0]         red_carry;

  //////////////////////////////
  // Three-stage pipeline
  //////////////////////////////

  sigmul_pp_decode #(
    .NSIG (NSIG)
  ) u_decode (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .a_frac     (a_frac),
    .b_frac     (b_frac),
    .a_zero_exp (a_zero_exp),
    .b_zero_exp (b_zero_exp),
    .pp_valid   (pp_valid),
    .pp_rows    (pp_rows)
  );

  sigmul_csa_tree #(
    .NSIG (NSIG)
  ) u_tree (
    .clk       (clk),
    .rst       (rst),
    .pp_valid  (pp_valid),
    .pp_rows   (pp_rows),
    .red_valid (red_valid),
    .red_sum   (red_sum),
    .red_carry (red_carry)
  );

  sigmul_result #(
    .NSIG (NSIG)
  ) u_result (
    .clk       (clk),
    .rst       (rst),
    .red_valid (red_valid),
    .red_sum   (red_sum),
    .red_carry (red_carry),
    .out_valid (out_valid),
    .sig       (sig),
    .exp_inc   (exp_inc),
    .guard     (guard),
    .sticky    (sticky)
  );

endmodule

/* dv/sigmul_checker.sv */
module sigmul_checker #(
  parameter int NSIG = sigmul_pkg::NSIG_DEFAULT
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic [NSIG-1:0] a_frac,
  input  logic [NSIG-1:0] b_frac,
  input  logic            a_zero_exp,
  input  logic            b_zero_exp,
  input  logic            out_valid,
  input  logic [sigmul_pkg::sig_width(NSIG)-1:0] sig,
  input  logic            exp_inc,
  input  logic            guard,
  input  logic            sticky,
  output int              mismatches,
  output int              other_errors,
  output int              pending,
  output int              checked
);

  timeunit 1ns;
  timeprecision 1ps;

  import sigmul_pkg::*;

  localparam int SW           = sig_width(NSIG);
  localparam int PW           = prod_width(NSIG);
  localparam int LATENCY      = 3;
  localparam int MISS_TIMEOUT = 20;

  typedef struct packed {
    logic [SW-1:0] sig;
    logic          exp_inc;
    logic          guard;
    logic          sticky;
  } result_t;

  result_t exp_q [$];
  int      cyc_q [$];
  int      cycle;
  int      mismatch_count;
  int      run_errors;
  int      level_errors;
  int      checked_count;
  bit      rst_prev;

  assign other_errors = run_errors + level_errors;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic result_t model(input logic [NSIG-1:0] af, input logic [NSIG-1:0] bf,
                                    input logic az, input logic bz);
    logic [PW-1:0] a_full;
    logic [PW-1:0] b_full;
    logic [PW-1:0] p;
    int            below;
    result_t       r;
    a_full    = PW'({(az ? 1'b0 : 1'b1), af});
    b_full    = PW'({(bz ? 1'b0 : 1'b1), bf});
    p         = a_full * b_full;
    r.exp_inc = p[PW-1];
    // Bits below the significand
    below     = r.exp_inc ? SW : SW - 1;
    r.sig     = SW'(p >> below);
    r.guard   = p[below-1];
    r.sticky  = (p & ((PW'(1) << (below - 1)) - PW'(1))) != '0;
    return r;
  endfunction

  // Tree depth from the 3:2 rule, three rows become two
  initial
  begin
    int n;
    int lv;
    n  = sig_width(NSIG);
    lv = 0;
    level_errors = 0;
    while (n > 2)
    begin
      n = n - n / 3;
      lv++;
    end
    if (lv != csa_levels(NSIG))
    begin
      $display("Reduction tree depth is %0d levels but should be %0d", csa_levels(NSIG), lv);
      level_errors = 1;
    end
  end

  //////////////////////////////
  // Comparison
  //////////////////////////////

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
    begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
      mismatch_count++;
    end
  endtask

  task automatic check_output();
    result_t e;
    int      lat;
    if (exp_q.size() == 0)
    begin
      $display("Unexpected result at %0t: out_valid with no operands outstanding", $time);
      run_errors++;
    end
    else
    begin
      e   = exp_q.pop_front();
      lat = cycle - cyc_q.pop_front();
      checked_count++;
      compare("sig", 64'(sig), 64'(e.sig));
      compare("exp_inc", 64'(exp_inc), 64'(e.exp_inc));
      compare("guard", 64'(guard), 64'(e.guard));
      compare("sticky", 64'(sticky), 64'(e.sticky));
      compare("latency", 64'(lat), 64'(LATENCY));
    end
  endtask

  always @(posedge clk)
  begin
    cycle++;
    if (rst_prev && out_valid === 1'b1)
    begin
      $display("Reset failure at %0t: out_valid high right after reset", $time);
      run_errors++;
    end
    else if (out_valid === 1'b1)
      check_output();

    if (rst === 1'b1)
    begin
      exp_q.delete();
      cyc_q.delete();
    end
    else
    begin
      if (in_valid === 1'b1)
      begin
        exp_q.push_back(model(a_frac, b_frac, a_zero_exp, b_zero_exp));
        cyc_q.push_back(cycle);
      end
      // Operands whose result is long overdue
      while (cyc_q.size() > 0 && cycle - cyc_q[0] > LATENCY + MISS_TIMEOUT)
      begin
        $display("Result for operands sent in cycle %0d never arrived", cyc_q[0]);
        void'(exp_q.pop_front());
        void'(cyc_q.pop_front());
        run_errors++;
      end
    end
    rst_prev = (rst === 1'b1);

    mismatches <= mismatch_count;
    pending    <= exp_q.size();
    checked    <= checked_count;
  end

endmodule

/* dv/sigmul_tb.sv */
module sigmul_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import sigmul_pkg::*;

  localparam int          NSIG          = NSIG_DEFAULT;
  localparam int          SW            = sig_width(NSIG);
  localparam int          CLK_PERIOD    = 8;
  localparam int          NUM_RANDOM    = 2000;
  localparam int          NUM_BURSTS    = 40;
  localparam int          NUM_SUBNORMAL = 400;
  localparam int          DRAIN_TIMEOUT = 40;
  localparam logic [31:0] SEED          = 32'ha422_35c8;

  logic            clk;
  logic            rst;
  logic            in_valid;
  logic [NSIG-1:0] a_frac;
  logic [NSIG-1:0] b_frac;
  logic            a_zero_exp;
  logic            b_zero_exp;
  logic            out_valid;
  logic [SW-1:0]   sig;
  logic            exp_inc;
  logic            guard;
  logic            sticky;
  int              mismatches;
  int              other_errors;
  int              pending;
  int              checked;
  int              tb_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  sigmul_top dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .a_frac     (a_frac),
    .b_frac     (b_frac),
    .a_zero_exp (a_zero_exp),
    .b_zero_exp (b_zero_exp),
    .out_valid  (out_valid),
    .sig        (sig),
    .exp_inc    (exp_inc),
    .guard      (guard),
    .sticky     (sticky)
  );

  sigmul_checker #(
    .NSIG (NSIG)
  ) u_checker (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .a_frac       (a_frac),
    .b_frac       (b_frac),
    .a_zero_exp   (a_zero_exp),
    .b_zero_exp   (b_zero_exp),
    .out_valid    (out_valid),
    .sig          (sig),
    .exp_inc      (exp_inc),
    .guard        (guard),
    .sticky       (sticky),
    .mismatches   (mismatches),
    .other_errors (other_errors),
    .pending      (pending),
    .checked      (checked)
  );

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [NSIG-1:0] rand_frac();
    return NSIG'({$urandom, $urandom});
  endfunction

  task automatic send_op(input logic [NSIG-1:0] a, input logic [NSIG-1:0] b,
                         input logic az, input logic bz);
    @(posedge clk);
    in_valid   <= 1'b1;
    a_frac     <= a;
    b_frac     <= b;
    a_zero_exp <= az;
    b_zero_exp <= bz;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // Call only after at least one idle cycle
  task automatic wait_drain();
    int waited;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
    end
    while (pending != 0 && waited < DRAIN_TIMEOUT);
    if (pending != 0)
    begin
      $display("Timeout: %0d results still outstanding after %0d cycles", pending, waited);
      tb_errors++;
    end
  endtask

  task automatic reset_mid_burst(input int len);
    repeat (len) send_op(rand_frac(), rand_frac(), 1'b0, 1'b0);
    // Operands keep coming while rst is high
    send_op(rand_frac(), rand_frac(), 1'b0, 1'b0);
    rst <= 1'b1;
    send_op(rand_frac(), rand_frac(), 1'b0, 1'b0);
    @(posedge clk);
    rst      <= 1'b0;
    in_valid <= 1'b0;
    idle(4);
    repeat (6) send_op(rand_frac(), rand_frac(), 1'b0, 1'b0);
    idle(2);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    int burst_len;
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    a_frac     = '0;
    b_frac     = '0;
    a_zero_exp = 1'b0;
    b_zero_exp = 1'b0;
    tb_errors  = 0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      send_op(rand_frac(), rand_frac(), 1'b0, 1'b0);
      idle(int'($urandom_range(2, 0)));
    end
    idle(1);
    wait_drain();

    // Back-to-back bursts
    for (int n = 0; n < NUM_BURSTS; n++)
    begin
      burst_len = int'($urandom_range(12, 2));
      repeat (burst_len) send_op(rand_frac(), rand_frac(), 1'b0, 1'b0);
      idle(int'($urandom_range(4, 1)));
    end
    wait_drain();

    // Subnormal mixes, zero products included
    for (int i = 0; i < NUM_SUBNORMAL; i++)
      send_op(rand_frac(), rand_frac(), 1'($urandom), 1'($urandom));
    send_op('0, rand_frac(), 1'b1, 1'b0);
    send_op(rand_frac(), '0, 1'b0, 1'b1);
    send_op('0, '0, 1'b1, 1'b1);
    idle(1);
    wait_drain();

    // Corner values
    send_op('1, '1, 1'b0, 1'b0);
    send_op('0, '0, 1'b0, 1'b0);
    send_op('1, '0, 1'b0, 1'b0);
    send_op('0, '1, 1'b0, 1'b0);
    send_op('1, '1, 1'b1, 1'b1);
    idle(1);
    wait_drain();

    reset_mid_burst(4);
    reset_mid_burst(int'($urandom_range(6, 1)));
    wait_drain();
    idle(2);

    $display("Checked %0d results: %0d mismatches, %0d other errors, %0d testbench errors",
             checked, mismatches, other_errors, tb_errors);
    if (mismatches + other_errors + tb_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* filelist.f */
logic/sigmul_pkg.sv
logic/sigmul_pp_decode.sv
logic/sigmul_csa_tree.sv
logic/sigmul_result.sv
logic/sigmul_top.sv
dv/sigmul_checker.sv
dv/sigmul_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the significand multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f filelist.f \
  --top-module sigmul_tb \
  -Mdir obj_dir -o sigmul_sim

./obj_dir/sigmul_sim > sim.log 2>&1
cat sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
